/* common/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;
    typedef logic [5:0]  opField;   // opcode and funct share a width
    typedef logic [15:0] immField;

    localparam int nRegs = 32;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOp;

    // primary opcodes
    localparam opField opSpecial = 6'b000000;
    localparam opField opAddiu   = 6'b001001;
    localparam opField opSlti    = 6'b001010;
    localparam opField opAndi    = 6'b001100;
    localparam opField opOri     = 6'b001101;
    localparam opField opXori    = 6'b001110;
    localparam opField opLui     = 6'b001111;

    // funct field under SPECIAL
    localparam opField fnSll  = 6'b000000;
    localparam opField fnSrl  = 6'b000010;
    localparam opField fnSra  = 6'b000011;
    localparam opField fnAddu = 6'b100001;
    localparam opField fnSubu = 6'b100011;
    localparam opField fnAnd  = 6'b100100;
    localparam opField fnOr   = 6'b100101;
    localparam opField fnXor  = 6'b100110;
    localparam opField fnNor  = 6'b100111;
    localparam opField fnSlt  = 6'b101010;
    localparam opField fnSltu = 6'b101011;

endpackage

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
    parameter mipsPkg::word ResetVector = 32'hbfc00000
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         freeze,
    input  mipsPkg::word instr,
    output mipsPkg::word pcF,
    output logic         instEn,
    output mipsPkg::word instrD,
    output mipsPkg::word pcD,
    output logic         validD
);
    import mipsPkg::*;

    word  pcPlus4;
    logic accept;   // fetch taken this cycle

    assign pcPlus4 = pcF + 32'd4;
    assign accept  = instEn & ~freeze;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF    <= ResetVector;
            instEn <= 1'b0;
        end else begin
            instEn <= 1'b1;     // fetch runs freely once out of reset
            if (accept)
                pcF <= pcPlus4;
        end
    end

    // fetch to decode register
    always_ff @(posedge clk) begin
        if (reset)
            validD <= 1'b0;
        else if (!freeze)
            validD <= accept;
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            instrD <= instr;
            pcD    <= pcF;
        end
    end

    assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
        else $error("pcF %h not word aligned", pcF);

    // cache stall must hold the fetch address
    assert property (@(posedge clk) disable iff (reset) freeze |=> $stable(pcF))
        else $error("pcF moved during stall");

endmodule

/* decode/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder (
    input  mipsPkg::word    instrD,
    input  logic            validD,
    output mipsPkg::aluOp   aluOpD,
    output logic            useImmD,
    output logic            signExtD,
    output mipsPkg::regAddr destD,
    output logic            writeEnD
);
    import mipsPkg::*;

    opField op;
    opField funct;
    regAddr rt;
    regAddr rd;
    logic   known;      // recognised instruction

    assign op    = instrD[31:26];
    assign funct = instrD[5:0];
    assign rt    = instrD[20:16];
    assign rd    = instrD[15:11];

    always_comb begin
        aluOpD   = aluAdd;
        useImmD  = 1'b0;
        signExtD = 1'b0;
        known    = 1'b1;
        if (op == opSpecial) begin
            case (funct)
                fnAddu:  aluOpD = aluAdd;
                fnSubu:  aluOpD = aluSub;
                fnAnd:   aluOpD = aluAnd;
                fnOr:    aluOpD = aluOr;
                fnXor:   aluOpD = aluXor;
                fnNor:   aluOpD = aluNor;
                fnSlt:   aluOpD = aluSlt;
                fnSltu:  aluOpD = aluSltu;
                fnSll:   aluOpD = aluSll;
                fnSrl:   aluOpD = aluSrl;
                fnSra:   aluOpD = aluSra;
                default: known  = 1'b0;
            endcase
        end else begin
            useImmD = 1'b1;
            case (op)
                opAddiu: begin
                    aluOpD   = aluAdd;
                    signExtD = 1'b1;
                end
                opSlti: begin
                    aluOpD   = aluSlt;
                    signExtD = 1'b1;
                end
                opAndi:  aluOpD = aluAnd;   // logical ops zero extend
                opOri:   aluOpD = aluOr;
                opXori:  aluOpD = aluXor;
                opLui:   aluOpD = aluLui;
                default: begin
                    useImmD = 1'b0;
                    known   = 1'b0;
                end
            endcase
        end
    end

    // rd for R-type, rt for immediates
    assign destD = (op == opSpecial) ? rd : rt;

    // no write for bubbles, unknown codes or r0
    assign writeEnD = validD & known & (destD != '0);

endmodule

/* decode/operandRead.sv */
`timescale 1ns/1ps

module operandRead (
    input  logic            clk,
    input  mipsPkg::word    instrD,
    input  logic            commitEn,
    input  mipsPkg::regAddr commitAddr,
    input  mipsPkg::word    commitData,
    output mipsPkg::word    rsValueD,
    output mipsPkg::word    rtValueD
);
    import mipsPkg::*;

    word    regs [nRegs];
    regAddr rs;
    regAddr rt;

    assign rs = instrD[25:21];
    assign rt = instrD[20:16];

    always_ff @(posedge clk) begin
        if (commitEn)
            regs[commitAddr] <= commitData;
    end

    // write first, so a commit this cycle is seen in decode at once
    function automatic word readPort(regAddr a);
        if (a == '0)
            return '0;
        else if (commitEn && commitAddr == a)
            return commitData;
        else
            return regs[a];
    endfunction

    always_comb begin
        rsValueD = readPort(rs);
        rtValueD = readPort(rt);
    end

    assert property (@(posedge clk) commitEn |-> commitAddr != '0)
        else $error("commit to r0 with data %h", commitData);

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            freeze,
    input  mipsPkg::word    pcD,
    input  mipsPkg::word    instrD,
    input  logic            validD,
    input  mipsPkg::aluOp   aluOpD,
    input  logic            useImmD,
    input  logic            signExtD,
    input  logic            writeEnD,
    input  mipsPkg::regAddr destD,
    input  mipsPkg::word    rsValueD,
    input  mipsPkg::word    rtValueD,
    output logic            commitEn,
    output mipsPkg::regAddr commitAddr,
    output mipsPkg::word    commitData,
    output mipsPkg::word    commitPc
);
    import mipsPkg::*;

    logic       validE;
    logic       writeEnE;
    word        pcE;
    word        instrE;
    aluOp       aluOpE;
    logic       useImmE;
    logic       signExtE;
    regAddr     destE;
    word        rsValueE;
    word        rtValueE;

    regAddr     rsE;
    regAddr     rtE;
    logic [4:0] saE;
    immField    immE;
    word        immExtE;
    word        rsFwd;
    word        rtFwd;
    word        srcA;
    word        srcB;
    word        aluOut;

    logic       validC;
    logic       writeEnC;

    // stage valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            validE   <= 1'b0;
            writeEnE <= 1'b0;
            validC   <= 1'b0;
            writeEnC <= 1'b0;
        end else if (!freeze) begin
            validE   <= validD;
            writeEnE <= writeEnD;
            validC   <= validE;
            writeEnC <= writeEnE;
        end
    end

    // decode to execute payload
    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcE      <= pcD;
            instrE   <= instrD;
            aluOpE   <= aluOpD;
            useImmE  <= useImmD;
            signExtE <= signExtD;
            destE    <= destD;
            rsValueE <= rsValueD;
            rtValueE <= rtValueD;
        end
    end

    assign rsE  = instrE[25:21];
    assign rtE  = instrE[20:16];
    assign saE  = instrE[10:6];
    assign immE = instrE[15:0];

    assign immExtE = signExtE ? {{16{immE[15]}}, immE} : {16'd0, immE};

    // previous instruction sits in commit, take its result
    assign rsFwd = (commitEn && commitAddr == rsE) ? commitData : rsValueE;
    assign rtFwd = (commitEn && commitAddr == rtE) ? commitData : rtValueE;

    assign srcA = rsFwd;
    assign srcB = useImmE ? immExtE : rtFwd;

    always_comb begin
        case (aluOpE)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluNor:  aluOut = ~(srcA | srcB);
            aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            aluSltu: aluOut = {31'd0, srcA < srcB};
            aluSll:  aluOut = srcB << saE;     // shifts act on rt
            aluSrl:  aluOut = srcB >> saE;
            aluSra:  aluOut = $signed(srcB) >>> saE;
            aluLui:  aluOut = {immE, 16'd0};
            default: aluOut = '0;
        endcase
    end

    // execute to commit payload
    always_ff @(posedge clk) begin
        if (!freeze) begin
            commitPc   <= pcE;
            commitAddr <= destE;
            commitData <= aluOut;
        end
    end

    assign commitEn = validC & writeEnC & ~freeze;

    assert property (@(posedge clk) disable iff (reset)
        validE |-> aluOpE inside {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
                                  aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui})
        else $error("bad aluOp %0d in execute", aluOpE);

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter mipsPkg::word ResetVector = 32'hbfc00000
) (
    input  logic            clk,
    input  logic            reset,
    output mipsPkg::word    pcF,
    output logic            instEn,
    input  mipsPkg::word    instr,
    input  logic            iCacheStall,
    output mipsPkg::word    debugWbPc,
    output logic [3:0]      debugWbRfWen,
    output mipsPkg::regAddr debugWbRfWnum,
    output mipsPkg::word    debugWbRfWdata
);
    import mipsPkg::*;

    logic   freeze;     // whole pipeline holds on cache stall

    word    instrD;
    word    pcD;
    logic   validD;
    aluOp   aluOpD;
    logic   useImmD;
    logic   signExtD;
    regAddr destD;
    logic   writeEnD;
    word    rsValueD;
    word    rtValueD;

    logic   commitEn;
    regAddr commitAddr;
    word    commitData;
    word    commitPc;

    assign freeze = iCacheStall;

    fetchUnit #(
        .ResetVector(ResetVector)
    ) fetchUnit_inst (
        .clk(clk),
        .reset(reset),
        .freeze(freeze),
        .instr(instr),
        .pcF(pcF),
        .instEn(instEn),
        .instrD(instrD),
        .pcD(pcD),
        .validD(validD)
    );

    mainDecoder mainDecoder_inst (
        .instrD(instrD),
        .validD(validD),
        .aluOpD(aluOpD),
        .useImmD(useImmD),
        .signExtD(signExtD),
        .destD(destD),
        .writeEnD(writeEnD)
    );

    operandRead operandRead_inst (
        .clk(clk),
        .instrD(instrD),
        .commitEn(commitEn),
        .commitAddr(commitAddr),
        .commitData(commitData),
        .rsValueD(rsValueD),
        .rtValueD(rtValueD)
    );

    executeStage executeStage_inst (
        .clk(clk),
        .reset(reset),
        .freeze(freeze),
        .pcD(pcD),
        .instrD(instrD),
        .validD(validD),
        .aluOpD(aluOpD),
        .useImmD(useImmD),
        .signExtD(signExtD),
        .writeEnD(writeEnD),
        .destD(destD),
        .rsValueD(rsValueD),
        .rtValueD(rtValueD),
        .commitEn(commitEn),
        .commitAddr(commitAddr),
        .commitData(commitData),
        .commitPc(commitPc)
    );

    // debug writeback port
    assign debugWbPc      = commitPc;
    assign debugWbRfWen   = {4{commitEn}};
    assign debugWbRfWnum  = commitAddr;
    assign debugWbRfWdata = commitData;

endmodule

/* sim/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;
    import mipsPkg::*;

    localparam word ResetVector   = 32'hbfc00000;
    localparam int  MaxEntries    = 64;
    localparam int  CommitTimeout = 1000;   // cycles per phase
    localparam int  DrainCycles   = 8;

    logic       clk;
    logic       reset;
    word        instr;
    logic       iCacheStall;
    word        pcF;
    logic       instEn;
    word        debugWbPc;
    logic [3:0] debugWbRfWen;
    regAddr     debugWbRfWnum;
    word        debugWbRfWdata;

    word         stimMem [1 + 3*MaxEntries];
    int          fetchCycle [MaxEntries];
    int          nEntries;
    int          expectedCommits;
    int          commitsSeen;
    int          commitPtr;
    int          cycleCount;
    logic        stallPhase;
    logic        prevStall;
    word         prevPc;
    logic [31:0] lfsrState;
    int          valueErrors;
    int          otherErrors;

    datapath #(
        .ResetVector(ResetVector)
    ) datapath_inst (
        .clk(clk),
        .reset(reset),
        .pcF(pcF),
        .instEn(instEn),
        .instr(instr),
        .iCacheStall(iCacheStall),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    always #2 clk = ~clk;

    function automatic word entryDest(int i);
        return stimMem[2 + 3*i];
    endfunction

    function automatic word entryValue(int i);
        return stimMem[3 + 3*i];
    endfunction

    // instruction memory returns zero past the program
    function automatic word fetchWord(word pc);
        word offset;
        offset = pc - ResetVector;
        if (offset < word'(4*nEntries))
            return stimMem[1 + 3*(offset >> 2)];
        return '0;
    endfunction

    function automatic int nextCommitIndex(int from);
        int i;
        i = from;
        while (i < nEntries && entryDest(i) == 0)
            i++;
        return i;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic checkValue(input string name, input word actual, input word expected);
        assert (actual === expected) else begin
            valueErrors++;
            $display("ERROR %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic observeCommit(input logic stall);
        int idx;
        if (stall)
            checkValue("debugWbRfWen", debugWbRfWen, 0);   // nothing commits in a stall
        if (debugWbRfWen != 4'h0) begin
            checkValue("debugWbRfWen", debugWbRfWen, 32'hf);
            assert (commitsSeen < expectedCommits) else begin
                otherErrors++;
                $display("unexpected commit to r%0d after the last expected one at %0t ns",
                         debugWbRfWnum, $time);
            end
            if (commitsSeen < expectedCommits) begin
                idx = nextCommitIndex(commitPtr);
                checkValue("debugWbPc", debugWbPc, ResetVector + 4*idx);
                checkValue("debugWbRfWnum", debugWbRfWnum, entryDest(idx));
                checkValue("debugWbRfWdata", debugWbRfWdata, entryValue(idx));
                if (!stallPhase)
                    checkValue("commit latency", cycleCount - fetchCycle[idx], 3);
                commitPtr = idx + 1;
                commitsSeen++;
            end
        end
    endtask

    task automatic stepCycle();
        logic bitA;
        logic bitB;
        logic stall;
        word  offset;
        @(negedge clk);
        if (prevStall)
            checkValue("pcF", pcF, prevPc);
        stall = 1'b0;
        if (stallPhase) begin
            lfsrState = lfsrNext(lfsrState);
            bitA = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
            bitB = lfsrState[0];
            stall = bitA & bitB;
        end
        iCacheStall = stall;
        instr = fetchWord(pcF);
        offset = pcF - ResetVector;
        if (instEn && !stall && offset < word'(4*nEntries))
            fetchCycle[offset >> 2] = cycleCount;   // accepted this cycle
        #1;
        observeCommit(stall);
        prevStall = stall;
        prevPc = pcF;
        cycleCount++;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        iCacheStall = 1'b0;
        instr = '0;
        prevStall = 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkValue("debugWbRfWen", debugWbRfWen, 0);
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        checkValue("pcF", pcF, ResetVector);
        checkValue("instEn", instEn, 1);
        checkValue("debugWbRfWen", debugWbRfWen, 0);
    endtask

    task automatic runProgram(input logic withStalls);
        int cycles;
        stallPhase = withStalls;
        applyReset();
        commitsSeen = 0;
        commitPtr = 0;
        cycles = 0;
        while (commitsSeen < expectedCommits && cycles < CommitTimeout) begin
            stepCycle();
            cycles++;
        end
        assert (commitsSeen == expectedCommits) else begin
            otherErrors++;
            $display("timed out waiting for commits, saw %0d of %0d", commitsSeen,
                     expectedCommits);
        end
        repeat (DrainCycles)
            stepCycle();    // trailing words must stay silent
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        iCacheStall = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount = 0;
        stallPhase = 1'b0;
        prevStall = 1'b0;
        prevPc = '0;
        lfsrState = 32'hb3416654;
        $readmemh("sim/datapathStim.txt", stimMem);
        nEntries = stimMem[0];
        assert (nEntries > 0 && nEntries <= MaxEntries) else begin
            otherErrors++;
            $display("stimulus file holds a bad entry count %0d", nEntries);
        end
        if (otherErrors == 0) begin
            expectedCommits = 0;
            for (int i = 0; i < nEntries; i++)
                if (entryDest(i) != 0)
                    expectedCommits++;
            runProgram(1'b0);
            @(negedge clk);
            runProgram(1'b1);
        end
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* datapath.f */
common/mipsPkg.sv
hdl/fetchUnit.sv
decode/mainDecoder.sv
decode/operandRead.sv
execute/executeStage.sv
hdl/datapath.sv
sim/datapathTb.sv

/* sim/datapathStim.txt */
// first word: number of program entries
// then one entry per line: instruction, expected destination (00 = no commit), expected value
0000001c
3c011234 01 12340000  // lui   r1, 0x1234
34215678 01 12345678  // ori   r1, r1, 0x5678
2402ffff 02 ffffffff  // addiu r2, r0, -1
00221821 03 12345677  // addu  r3, r1, r2
00612023 04 ffffffff  // subu  r4, r3, r1
00222824 05 12345678  // and   r5, r1, r2
00813025 06 ffffffff  // or    r6, r4, r1
00263826 07 edcba987  // xor   r7, r1, r6
00204027 08 edcba987  // nor   r8, r1, r0
0041482a 09 00000001  // slt   r9, r2, r1
0041502b 0a 00000000  // sltu  r10, r2, r1
00015900 0b 23456780  // sll   r11, r1, 4
00026202 0c 00ffffff  // srl   r12, r2, 8
00076903 0d fedcba98  // sra   r13, r7, 4
242e8000 0e 1233d678  // addiu r14, r1, -32768
288f0001 0f 00000001  // slti  r15, r4, 1
30508001 10 00008001  // andi  r16, r2, 0x8001
3411f0f0 11 0000f0f0  // ori   r17, r0, 0xf0f0
3a32ffff 12 00000f0f  // xori  r18, r17, 0xffff
00220021 00 00000000  // addu  r0, r1, r2
fc430001 00 00000000  // unknown opcode
0022183f 00 00000000  // unknown funct
00129821 13 00000f0f  // addu  r19, r0, r18
3c14ffff 14 ffff0000  // lui   r20, 0xffff
0014ac03 15 ffffffff  // sra   r21, r20, 16
02b4b023 16 0000ffff  // subu  r22, r21, r20
02d60821 01 0001fffe  // addu  r1, r22, r22
0001b842 17 0000ffff  // srl   r23, r1, 1
